//--- source/fp_sum_pkg.sv
package fp_sum_pkg;

	// Frame and pipeline sizes
	localparam int N_SAMPLES = 25; // Samples per frame
	localparam int L_ADD = 4; // fp32_add latency in cycles
	localparam int N_LEVELS = 5; // Adder tree depth

	// One gather cycle, then every tree level in turn
	localparam int L_TOTAL = 1 + N_LEVELS * L_ADD;

	// Index into the current frame
	typedef logic [$clog2(N_SAMPLES)-1:0] sample_idx_t;

	localparam sample_idx_t LAST_IDX = sample_idx_t'(N_SAMPLES - 1); // Slot of the closing sample

	// IEEE-754 single precision fields
	typedef struct packed {
		logic        sign;
		logic [7:0]  exponent;
		logic [22:0] mantissa; // Hidden bit not stored
	} fp32_fields_t;

	// Same float word, seen as raw bits or as fields
	typedef union packed {
		logic [31:0]  bits;
		fp32_fields_t f;
	} fp32_t;

	// A complete frame handed from the gather stage to the tree
	typedef struct packed {
		logic                        valid; // Single-cycle launch strobe
		fp32_t [N_SAMPLES-1:0]       samples; // Sample 0 in the low slot
	} sum_frame_t;

endpackage

//--- source/sample_gather.sv
module sample_gather (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   i_valid,
	input  fp_sum_pkg::fp32_t      i_data,
	output fp_sum_pkg::sum_frame_t o_frame
);

	fp_sum_pkg::sample_idx_t cnt_q; // Next free slot

	// Holds samples 0..23, the closing sample bypasses it
	fp_sum_pkg::fp32_t [fp_sum_pkg::N_SAMPLES-2:0] sample_buf;

	fp_sum_pkg::fp32_t [fp_sum_pkg::N_SAMPLES-1:0] frame_data_q;
	logic                                         frame_valid_q;
	logic                                         last_sample;

	assign last_sample = i_valid && (cnt_q == fp_sum_pkg::LAST_IDX);

	// Counter and launch strobe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt_q         <= '0; // Partial frame dropped
			frame_valid_q <= 1'b0;
		end else begin
			frame_valid_q <= last_sample; // High for one cycle only
			if (last_sample) begin
				cnt_q <= '0;
			end else if (i_valid) begin
				cnt_q <= cnt_q + 1'b1;
			end
		end
	end

	// Sample storage and frame register
	always_ff @(posedge clk) begin
		if (i_valid && !last_sample) begin
			sample_buf[cnt_q] <= i_data;
		end
		if (last_sample) begin
			frame_data_q <= {i_data, sample_buf}; // Closing sample lands in slot 24
		end
	end

	// Buffer refills while the launched frame sits in frame_data_q
	assign o_frame = '{valid: frame_valid_q, samples: frame_data_q};

endmodule

//--- source/fp32_add.sv
module fp32_add (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              i_valid,
	input  fp_sum_pkg::fp32_t i_a,
	input  fp_sum_pkg::fp32_t i_b,
	output logic              o_valid,
	output fp_sum_pkg::fp32_t o_sum
);

	// Position of the leading one in a 28-bit sum, 28 when zero
	function automatic logic [4:0] count_lz(input logic [27:0] v);
		logic [4:0] n;
		logic       found;
		n     = 5'd0;
		found = 1'b0;
		for (int i = 27; i >= 0; i--) begin
			if (!found) begin
				if (v[i]) begin
					found = 1'b1;
				end else begin
					n = n + 5'd1;
				end
			end
		end
		return n;
	endfunction

	// Stage 1 unpack and order
	logic [7:0]  a_exp;
	logic [7:0]  b_exp;
	logic [23:0] a_man;
	logic [23:0] b_man;
	logic        a_ge_b;

	logic        s1_sign;
	logic        s1_sub;
	logic [7:0]  s1_exp;
	logic [7:0]  s1_diff;
	logic [23:0] s1_man_big;
	logic [23:0] s1_man_small;

	always_comb begin
		a_exp  = i_a.f.exponent;
		b_exp  = i_b.f.exponent;
		a_man  = (a_exp == 8'd0) ? 24'd0 : {1'b1, i_a.f.mantissa}; // Subnormal to zero
		b_man  = (b_exp == 8'd0) ? 24'd0 : {1'b1, i_b.f.mantissa};
		a_ge_b = {a_exp, a_man} >= {b_exp, b_man}; // Magnitude compare
	end

	always_ff @(posedge clk) begin
		s1_sub <= i_a.f.sign ^ i_b.f.sign; // Effective subtraction
		if (a_ge_b) begin
			s1_sign      <= i_a.f.sign;
			s1_exp       <= a_exp;
			s1_diff      <= a_exp - b_exp;
			s1_man_big   <= a_man;
			s1_man_small <= b_man;
		end else begin
			s1_sign      <= i_b.f.sign;
			s1_exp       <= b_exp;
			s1_diff      <= b_exp - a_exp;
			s1_man_big   <= b_man;
			s1_man_small <= a_man;
		end
	end

	// Stage 2 alignment
	logic [4:0]  shamt;
	logic [49:0] small_wide;

	logic        s2_sign;
	logic        s2_sub;
	logic [7:0]  s2_exp;
	logic [23:0] s2_man_big;
	logic [26:0] s2_man_small; // Mantissa, guard, round, sticky

	always_comb begin
		// Beyond 26 every bit ends up in sticky anyway
		shamt      = (s1_diff > 8'd26) ? 5'd26 : s1_diff[4:0];
		small_wide = {s1_man_small, 26'd0} >> shamt;
	end

	always_ff @(posedge clk) begin
		s2_sign      <= s1_sign;
		s2_sub       <= s1_sub;
		s2_exp       <= s1_exp;
		s2_man_big   <= s1_man_big;
		s2_man_small <= {small_wide[49:24], |small_wide[23:0]};
	end

	// Stage 3 add and leading zero count
	logic [27:0] big_ext;
	logic [27:0] small_ext;
	logic [27:0] raw_sum;

	logic        s3_sign;
	logic [7:0]  s3_exp;
	logic [27:0] s3_sum;
	logic [4:0]  s3_lz;

	always_comb begin
		big_ext   = {1'b0, s2_man_big, 3'd0};
		small_ext = {1'b0, s2_man_small};
		raw_sum   = s2_sub ? (big_ext - small_ext) : (big_ext + small_ext); // Never negative
	end

	always_ff @(posedge clk) begin
		s3_sign <= s2_sign;
		s3_exp  <= s2_exp;
		s3_sum  <= raw_sum;
		s3_lz   <= count_lz(raw_sum);
	end

	// Stage 4 normalize, round, pack
	logic [27:0] norm;
	logic        round_up;
	logic [23:0] man_r;
	logic [9:0]  exp_r; // Bit 9 set means negative
	logic [31:0] result;

	fp_sum_pkg::fp32_t sum_q;

	always_comb begin
		norm     = s3_sum << s3_lz; // Leading one to bit 27
		round_up = norm[3] & ((|norm[2:0]) | norm[4]); // Nearest, ties to even
		man_r    = {1'b0, norm[26:4]} + {23'd0, round_up};
		// Bit 26 of the raw sum carries the operand exponent
		exp_r    = 10'(s3_exp) + 10'd1 - 10'(s3_lz) + 10'(man_r[23]);

		if (s3_sum == 28'd0) begin
			result = 32'd0; // Exact zero is +0
		end else if (exp_r[9] || exp_r == 10'd0) begin
			result = {s3_sign, 31'd0}; // Underflow flush
		end else if (exp_r >= 10'd255) begin
			result = {s3_sign, 8'hfe, 23'h7fffff}; // Saturate
		end else begin
			result = {s3_sign, exp_r[7:0], man_r[22:0]}; // Mantissa rollover leaves zeros
		end
	end

	always_ff @(posedge clk) begin
		sum_q.bits <= result;
	end

	assign o_sum = sum_q;

	// Valid travels with the data
	logic [fp_sum_pkg::L_ADD-1:0] vld_sr;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			vld_sr <= '0;
		end else begin
			vld_sr <= {vld_sr[fp_sum_pkg::L_ADD-2:0], i_valid};
		end
	end

	assign o_valid = vld_sr[fp_sum_pkg::L_ADD-1];

endmodule

//--- source/add_tree_level.sv
module add_tree_level #(
	parameter int N_IN = 25
) (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              i_valid,
	input  fp_sum_pkg::fp32_t [N_IN-1:0]       i_data,
	output logic                              o_valid,
	output fp_sum_pkg::fp32_t [(N_IN+1)/2-1:0] o_data
);

	logic [N_IN/2-1:0] pair_valid;

	// Inputs 2k and 2k+1 feed adder k
	for (genvar k = 0; k < N_IN / 2; k++) begin : g_pair
		fp32_add u_add (
			.clk     (clk),
			.rst_n   (rst_n),
			.i_valid (i_valid),
			.i_a     (i_data[2*k]),
			.i_b     (i_data[2*k+1]),
			.o_valid (pair_valid[k]),
			.o_sum   (o_data[k])
		);
	end

	assign o_valid = pair_valid[0]; // Adders run in lockstep

	// Odd leftover waits one adder latency for its partner
	if (N_IN % 2 == 1) begin : g_odd
		fp_sum_pkg::fp32_t [fp_sum_pkg::L_ADD-1:0] dly_q;
		logic [fp_sum_pkg::L_ADD-2:0]               dly_v;

		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				dly_v <= '0;
			end else begin
				dly_v <= {dly_v[fp_sum_pkg::L_ADD-3:0], i_valid};
			end
		end

		// Stages hold between frames
		always_ff @(posedge clk) begin
			if (i_valid) begin
				dly_q[0] <= i_data[N_IN-1];
			end
			for (int j = 1; j < fp_sum_pkg::L_ADD; j++) begin
				if (dly_v[j-1]) begin
					dly_q[j] <= dly_q[j-1];
				end
			end
		end

		assign o_data[(N_IN+1)/2-1] = dly_q[fp_sum_pkg::L_ADD-1]; // Last output slot
	end

endmodule

//--- source/fp_sum25_top.sv
module fp_sum25_top (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              i_valid,
	input  fp_sum_pkg::fp32_t i_data,
	output logic              o_valid,
	output fp_sum_pkg::fp32_t o_data
);

	fp_sum_pkg::sum_frame_t gather_frame;

	logic                     lvl1_valid;
	fp_sum_pkg::fp32_t [12:0] lvl1_data;
	logic                     lvl2_valid;
	fp_sum_pkg::fp32_t [6:0]  lvl2_data;
	logic                     lvl3_valid;
	fp_sum_pkg::fp32_t [3:0]  lvl3_data;
	logic                     lvl4_valid;
	fp_sum_pkg::fp32_t [1:0]  lvl4_data;
	fp_sum_pkg::fp32_t [0:0]  lvl5_data;

	sample_gather u_gather (.clk(clk), .rst_n(rst_n), .i_valid(i_valid), .i_data(i_data),
		.o_frame(gather_frame));

	add_tree_level #(.N_IN(25)) u_lvl1 (.clk(clk), .rst_n(rst_n),
		.i_valid(gather_frame.valid), .i_data(gather_frame.samples),
		.o_valid(lvl1_valid), .o_data(lvl1_data)); // 25 to 13

	add_tree_level #(.N_IN(13)) u_lvl2 (.clk(clk), .rst_n(rst_n), .i_valid(lvl1_valid),
		.i_data(lvl1_data), .o_valid(lvl2_valid), .o_data(lvl2_data)); // 13 to 7

	add_tree_level #(.N_IN(7)) u_lvl3 (.clk(clk), .rst_n(rst_n), .i_valid(lvl2_valid),
		.i_data(lvl2_data), .o_valid(lvl3_valid), .o_data(lvl3_data)); // 7 to 4

	add_tree_level #(.N_IN(4)) u_lvl4 (.clk(clk), .rst_n(rst_n), .i_valid(lvl3_valid),
		.i_data(lvl3_data), .o_valid(lvl4_valid), .o_data(lvl4_data));

	add_tree_level #(.N_IN(2)) u_lvl5 (.clk(clk), .rst_n(rst_n), .i_valid(lvl4_valid),
		.i_data(lvl4_data), .o_valid(o_valid), .o_data(lvl5_data)); // Final sum

	assign o_data = lvl5_data[0];

endmodule

//--- tb/fp_sum_props.sv
module fp_sum_props (
	input logic clk,
	input logic rst_n,
	input logic gather_valid,
	input logic o_valid
);
	timeunit 1ns;
	timeprecision 1ps;

	// Reset clears every valid flag in the tree
	a_quiet_in_reset : assert property (
		@(posedge clk) !rst_n |-> !o_valid
	) else $error("o_valid high while rst_n is low");

	// Frames are at least 25 cycles apart
	a_single_pulse : assert property (
		@(posedge clk) disable iff (!rst_n)
		o_valid |=> !o_valid
	) else $error("o_valid high in two consecutive cycles");

	// Gather launch is already one cycle into the frame latency
	a_launch_to_result : assert property (
		@(posedge clk) disable iff (!rst_n)
		gather_valid |-> ##(fp_sum_pkg::L_TOTAL - 1) o_valid
	) else $error("no sum at the output after a frame launch");

endmodule

//--- tb/fp_sum_tb.sv
module fp_sum_tb;
	timeunit 1ns;
	timeprecision 1ps;

	logic              clk;
	logic              rst_n;
	logic              i_valid;
	fp_sum_pkg::fp32_t i_data;
	logic              o_valid;
	fp_sum_pkg::fp32_t o_data;

	// Golden file contents
	int          n_frames;
	int          gap_mode [$]; // 0 back to back, 1 random gaps, 2 reset first
	logic [31:0] samples [$]; // N_SAMPLES words per frame
	logic [31:0] golden_sum [$];
	string       words [$];

	// Frames launched and not yet seen at the output
	logic [31:0] exp_sum_q [$];
	int          exp_cycle_q [$];
	string       exp_name_q [$];

	int cyc; // Rising edges so far
	int data_errs;
	int latency_errs;
	int other_errs;

	fp_sum25_top u_dut (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_valid (i_valid),
		.i_data  (i_data),
		.o_valid (o_valid),
		.o_data  (o_data)
	);

	bind fp_sum25_top fp_sum_props u_props (
		.clk          (clk),
		.rst_n        (rst_n),
		.gather_valid (gather_frame.valid),
		.o_valid      (o_valid)
	);

	always #50 clk = ~clk;

	always @(posedge clk) cyc <= cyc + 1;

	function automatic bit is_blank(input byte c);
		return c == " " || c == "\t" || c == "\n" || c == "\r";
	endfunction

	// Breaks one text line into blank separated words
	function automatic void split_line(input string line);
		int start;
		words.delete();
		start = 0;
		for (int i = 0; i <= line.len(); i++) begin
			if (i == line.len() || is_blank(line[i])) begin
				if (i > start) begin
					words.push_back(line.substr(start, i - 1));
				end
				start = i + 1;
			end
		end
	endfunction

	task automatic load_golden();
		int    fd;
		string line;
		fd = $fopen("tb/fp_sum_golden.txt", "r");
		if (fd == 0) begin
			$display("ERROR: cannot open tb/fp_sum_golden.txt");
			other_errs++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			split_line(line);
			if (words.size() == 0 || words[0].substr(0, 0) == "#") begin
				continue; // Blank or column description
			end
			if (words.size() != fp_sum_pkg::N_SAMPLES + 2) begin
				$display("ERROR: golden line with %0d fields skipped", words.size());
				other_errs++;
				continue;
			end
			gap_mode.push_back(words[0].atoi());
			for (int k = 1; k <= fp_sum_pkg::N_SAMPLES; k++) begin
				samples.push_back(words[k].atohex());
			end
			golden_sum.push_back(words[fp_sum_pkg::N_SAMPLES + 1].atohex());
			n_frames++;
		end
		$fclose(fd);
	endtask

	// Inputs change 10 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#10;
	endtask

	task automatic idle_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			next_cycle();
			i_valid     = 1'b0;
			i_data.bits = $urandom; // Ignored while idle
		end
	endtask

	task automatic send_sample(input logic [31:0] w);
		next_cycle();
		i_valid     = 1'b1;
		i_data.bits = w;
	endtask

	// Drain the tree, leave a partial frame behind and reset over it
	task automatic reset_mid_frame();
		while (exp_sum_q.size() != 0) begin
			idle_cycles(1);
		end
		for (int s = 0; s < 10; s++) begin
			send_sample($urandom);
		end
		next_cycle();
		i_valid = 1'b0;
		rst_n   = 1'b0;
		idle_cycles(3);
		rst_n = 1'b1;
	endtask

	task automatic send_frame(input int idx);
		for (int s = 0; s < fp_sum_pkg::N_SAMPLES; s++) begin
			if (gap_mode[idx] == 1) begin
				idle_cycles($urandom_range(3, 0));
			end
			send_sample(samples[idx * fp_sum_pkg::N_SAMPLES + s]);
		end
		// cyc is the edge that opened the closing sample's cycle
		exp_sum_q.push_back(golden_sum[idx]);
		exp_cycle_q.push_back(cyc + fp_sum_pkg::L_TOTAL);
		exp_name_q.push_back($sformatf("frame%0d", idx));
	endtask

	// Outputs are stable at the falling edge
	always @(negedge clk) begin : check_results
		logic [31:0] want;
		int          want_cyc;
		string       name;
		if (o_valid) begin
			assert (exp_sum_q.size() != 0) else begin
				$display("ERROR: a sum came out with no frame outstanding at cycle %0d", cyc);
				other_errs++;
			end
			if (exp_sum_q.size() != 0) begin
				want     = exp_sum_q.pop_front();
				want_cyc = exp_cycle_q.pop_front();
				name     = exp_name_q.pop_front();
				assert (o_data.bits == want) else begin
					$display("MISMATCH %s: expected %08h, actual %08h", name, want, o_data.bits);
					data_errs++;
				end
				assert (cyc == want_cyc) else begin
					$display("MISMATCH %s latency: expected cycle %0d, actual cycle %0d",
						name, want_cyc, cyc);
					latency_errs++;
				end
			end
		end
	end

	// Worst case is 4 cycles per sample with random gaps
	initial begin : watchdog
		wait (n_frames > 0);
		repeat (n_frames * fp_sum_pkg::N_SAMPLES * 4 + 200) @(posedge clk);
		other_errs++;
		$display("ERROR: timeout with %0d sums never produced", exp_sum_q.size());
		$display("Errors: data %0d, latency %0d, other %0d", data_errs, latency_errs,
			other_errs);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		void'($urandom(29));
		clk          = 1'b0;
		rst_n        = 1'b0;
		i_valid      = 1'b0;
		i_data.bits  = '0;
		cyc          = 0;
		n_frames     = 0;
		data_errs    = 0;
		latency_errs = 0;
		other_errs   = 0;
		load_golden();
		if (n_frames == 0) begin
			$display("ERROR: no frames were read from the golden file");
			other_errs++;
		end
		repeat (3) @(posedge clk);
		#10;
		rst_n = 1'b1;
		for (int f = 0; f < n_frames; f++) begin
			if (gap_mode[f] == 2) begin
				reset_mid_frame();
			end
			send_frame(f); // Mode 0 follows the previous frame directly
		end
		idle_cycles(1);
		while (exp_sum_q.size() != 0) begin
			idle_cycles(1);
		end
		idle_cycles(4); // Catch any stray o_valid
		$display("Errors: data %0d, latency %0d, other %0d", data_errs, latency_errs,
			other_errs);
		if (data_errs + latency_errs + other_errs == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

//--- tb/fp_sum_golden.txt
# gap mode (0 back to back, 1 random idle gaps, 2 partial frame and reset first), samples 0..24 hex
# last column is the expected sum in hex, tree pairing order, round to nearest even
0 3F800000 40000000 40400000 40800000 40A00000 40C00000 40E00000 41000000 41100000 41200000 41300000 41400000 41500000 41600000 41700000 41800000 41880000 41900000 41980000 41A00000 41A80000 41B00000 41B80000 41C00000 41C80000 43A28000
0 3F000000 3F000000 3F000000 3F000000 3F000000 3F000000 3F000000 3F000000 3F000000 3F000000 3F000000 3F000000 3F000000 3F000000 3F000000 3F000000 3F000000 3F000000 3F000000 3F000000 3F000000 3F000000 3F000000 3F000000 3F000000 41480000
0 BF800000 C0000000 C0400000 C0800000 C0A00000 C0C00000 C0E00000 C1000000 C1100000 C1200000 C1300000 C1400000 C1500000 C1600000 C1700000 C1800000 C1880000 C1900000 C1980000 C1A00000 C1A80000 C1B00000 C1B80000 C1C00000 C1C80000 C3A28000
1 3FC00000 3FC00000 3FC00000 3FC00000 3FC00000 3FC00000 3FC00000 3FC00000 3FC00000 3FC00000 3FC00000 3FC00000 3FC00000 3FC00000 3FC00000 3FC00000 3FC00000 3FC00000 3FC00000 3FC00000 3FC00000 3FC00000 3FC00000 3FC00000 3FC00000 42160000
1 42C80000 3E000000 42C80000 3E000000 42C80000 3E000000 42C80000 3E000000 42C80000 3E000000 42C80000 3E000000 42C80000 3E000000 42C80000 3E000000 42C80000 3E000000 42C80000 3E000000 42C80000 3E000000 42C80000 3E000000 42C80000 44A2B000
0 40A00000 3F800000 C0400000 C0400000 42C80000 C2C80000 3E000000 BE000000 40F00000 C0F00000 40F00000 C0F00000 40F00000 C0F00000 40F00000 C0F00000 41200000 41A00000 C1F00000 00000000 BF000000 3E800000 3E000000 3E000000 80000001 00000000
0 4B800000 3F800000 4B800001 3F800000 3F800000 33820000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 4C000001
2 40000000 40000000 40000000 40000000 40000000 40000000 40000000 40000000 40000000 40000000 40000000 40000000 40000000 40000000 40000000 40000000 40000000 40000000 40000000 40000000 40000000 40000000 40000000 40000000 40000000 42480000
0 40400000 40400000 40400000 40400000 40400000 40400000 40400000 40400000 40400000 40400000 40400000 40400000 40400000 40400000 40400000 40400000 40400000 40400000 40400000 40400000 40400000 40400000 40400000 40400000 40400000 42960000

//--- files.f
source/fp_sum_pkg.sv
source/sample_gather.sv
source/fp32_add.sv
source/add_tree_level.sv
source/fp_sum25_top.sv
tb/fp_sum_props.sv
tb/fp_sum_tb.sv

//--- run_sim.sh
#!/bin/bash
# Builds the fp_sum testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	--top-module fp_sum_tb -o fp_sum_sim -f files.f \
	|| { echo "Verilator build failed"; exit 1; }

./obj_dir/fp_sum_sim > sim.log 2>&1
cat sim.log

grep -q "STATUS: FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "Simulation ended without a verdict"; exit 1; }
echo "Simulation passed"
